// ==== Bender.yml ====
package:
  name: motion_detect

sources:
  - include_dirs:
      - include
    files:
      - design/motion_pkg.sv
      - design/bg_model_ram.sv
      - design/pixel_fetch.sv
      - design/adaptive_background.sv
      - design/motion_stats.sv
      - design/detect_ctrl.sv
      - design/motion_detect_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_motion_detect.sv

// ==== design/adaptive_background.sv ====
// three-stage foreground decision and background update
// dual learning rate, clamped result, capture path for the first frame
`timescale 1ns/1ps
`default_nettype none

`include "motion_settings.svh"

module adaptive_background
    import motion_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  fetch_beat_t beat,
    input  pixel_t      bg_pixel,
    input  logic        load_frame,
    input  thresh_t     threshold,
    output bg_wr_t      bg_wr,
    output fg_out_t     fg_out
);

    // ======================================================================
    // stage registers
    // ======================================================================
    // p1 latches inputs, p2 holds the decision, p3 holds the new model value
    addr_t              addr_p1;
    pixel_t             live_p1;
    pixel_t             bg_p1;
    thresh_t            thresh_p1;
    logic               act_p1;
    logic               load_p1;

    addr_t              addr_p2;
    pixel_t             live_p2;
    pixel_t             bg_p2;
    logic signed [8:0]  diff_p2;
    logic               fg_p2;
    logic               act_p2;
    logic               load_p2;

    addr_t              addr_p3;
    pixel_t             live_p3;
    pixel_t             new_bg_p3;
    logic               fg_p3;
    logic               act_p3;
    logic               load_p3;

    // ======================================================================
    // combinational stage logic
    // ======================================================================
    logic signed [8:0]  diff_p1;    // live minus model, -255..255
    logic [8:0]         abs_p1;
    logic               fg_p1;
    logic signed [8:0]  delta_p2;   // learning step after the shift
    logic signed [9:0]  sum_p2;     // model plus step, may leave 0..255
    pixel_t             new_bg_p2;

    assign diff_p1 = {1'b0, live_p1} - {1'b0, bg_p1};
    assign abs_p1  = diff_p1[8] ? 9'(-diff_p1) : diff_p1;
    assign fg_p1   = abs_p1 > thresh_p1;                    // strictly above

    // arithmetic shift keeps the sign, so dark and bright drift both work
    assign delta_p2 = fg_p2 ? (diff_p2 >>> `MD_FG_SHIFT) : (diff_p2 >>> `MD_BG_SHIFT);
    assign sum_p2   = $signed({2'b00, bg_p2}) + delta_p2;

    always_comb begin
        if (sum_p2 < 0) begin
            new_bg_p2 = '0;                                 // clamp low
        end else if (sum_p2 > 10'sd255) begin
            new_bg_p2 = '1;                                 // clamp high
        end else begin
            new_bg_p2 = sum_p2[7:0];
        end
    end

    // valid and load bits, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            act_p1  <= 1'b0;
            load_p1 <= 1'b0;
            act_p2  <= 1'b0;
            load_p2 <= 1'b0;
            act_p3  <= 1'b0;
            load_p3 <= 1'b0;
        end else if (enable) begin
            act_p1  <= beat.active;
            load_p1 <= load_frame;
            act_p2  <= act_p1;
            load_p2 <= load_p1;
            act_p3  <= act_p2;
            load_p3 <= load_p2;
        end
    end

    // data path, frozen while the pipe is disabled
    always_ff @(posedge clk) begin
        if (enable) begin
            addr_p1   <= beat.addr;
            live_p1   <= beat.pixel;
            bg_p1     <= bg_pixel;
            thresh_p1 <= threshold;

            addr_p2   <= addr_p1;
            live_p2   <= live_p1;
            bg_p2     <= bg_p1;
            diff_p2   <= diff_p1;
            fg_p2     <= fg_p1;

            addr_p3   <= addr_p2;
            live_p3   <= live_p2;
            new_bg_p3 <= new_bg_p2;
            fg_p3     <= fg_p2;
        end
    end

    // ======================================================================
    // outputs
    // ======================================================================
    assign bg_wr.en   = act_p3 | load_p3;
    assign bg_wr.addr = addr_p3;
    assign bg_wr.data = load_p3 ? live_p3 : new_bg_p3;     // capture takes the live value

    assign fg_out.valid = act_p3;
    assign fg_out.addr  = addr_p3;
    assign fg_out.flag  = fg_p3;
    assign fg_out.pixel = fg_p3 ? live_p3 : '0;

endmodule

`default_nettype wire

// ==== design/bg_model_ram.sv ====
// background model store
// one registered read port, one write port
`timescale 1ns/1ps
`default_nettype none

`include "motion_settings.svh"

module bg_model_ram
    import motion_pkg::*;
(
    input  logic   clk,
    input  addr_t  rd_addr,
    output pixel_t rd_data,
    input  bg_wr_t wr
);

    pixel_t mem [`MD_FRAME_PIXELS];   // one word per pixel position

    // read and write never hit the same word in one cycle
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data <= mem[rd_addr];        // data valid one cycle after the address
    end

endmodule

`default_nettype wire

// ==== design/detect_ctrl.sv ====
// run-state FSM of the motion detector
// accept, capture and pipeline-enable levels, stop handling and drain
`timescale 1ns/1ps
`default_nettype none

`include "motion_settings.svh"

module detect_ctrl
    import motion_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic stop,
    input  logic sof,
    input  logic frame_done,
    output logic accept,
    output logic load_frame,
    output logic pipe_en,
    output logic busy
);

    localparam int DRAIN_W = $clog2(`MD_PIPE_DEPTH + 2);

    det_state_e         state, next_state;
    logic               stop_pend;          // stop seen, act on next frame end
    logic [DRAIN_W-1:0] drain_cnt;
    logic               cap_d1, cap_d2;     // capture level delayed to the fetch output

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (start) next_state = ARM;
            ARM:     if (sof) next_state = CAPTURE;
            CAPTURE: if (frame_done) next_state = TRACK;        // model now loaded
            TRACK:   if (frame_done && stop_pend) next_state = DRAIN;
            DRAIN:   if (drain_cnt == DRAIN_W'(`MD_PIPE_DEPTH)) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            stop_pend <= 1'b0;
            drain_cnt <= '0;
            cap_d1    <= 1'b0;
            cap_d2    <= 1'b0;
        end else begin
            state     <= next_state;
            stop_pend <= (state == IDLE) ? 1'b0 : (stop_pend | stop);
            drain_cnt <= (state == DRAIN) ? drain_cnt + 1'b1 : '0;
            cap_d1    <= (state == CAPTURE);
            cap_d2    <= cap_d1;            // two fetch registers between pixel and pipe
        end
    end

    assign accept     = (state == CAPTURE) || (state == TRACK);
    assign load_frame = cap_d2;
    assign pipe_en    = (state != IDLE);    // drain flushes the last frame
    assign busy       = (state != IDLE);

endmodule

`default_nettype wire

// ==== design/motion_detect_top.sv ====
// motion detector top level
// control, fetch, model memory, update pipeline and frame statistics
`timescale 1ns/1ps
`default_nettype none

module motion_detect_top
    import motion_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  cam_beat_t    cam,
    input  logic         start,
    input  logic         stop,
    input  thresh_t      threshold,
    input  count_t       alarm_level,
    output fg_out_t      fg_out,
    output frame_stats_t stats,
    output logic         stats_valid,
    output logic         busy
);

    // ======================================================================
    // internal nets
    // ======================================================================
    logic        accept;
    logic        load_frame;
    logic        pipe_en;
    logic        frame_done;
    addr_t       rd_addr;
    pixel_t      rd_data;
    fetch_beat_t beat;
    bg_wr_t      bg_wr;

    detect_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .stop       (stop),
        .sof        (cam.sof),
        .frame_done (frame_done),
        .accept     (accept),
        .load_frame (load_frame),
        .pipe_en    (pipe_en),
        .busy       (busy)
    );

    pixel_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .cam        (cam),
        .accept     (accept),
        .rd_addr    (rd_addr),
        .beat       (beat),
        .frame_done (frame_done)
    );

    bg_model_ram u_ram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr      (bg_wr)        // written back from the last pipe stage
    );

    adaptive_background u_bg (
        .clk        (clk),
        .rst        (rst),
        .enable     (pipe_en),
        .beat       (beat),
        .bg_pixel   (rd_data),
        .load_frame (load_frame),
        .threshold  (threshold),
        .bg_wr      (bg_wr),
        .fg_out     (fg_out)
    );

    motion_stats u_stats (
        .clk         (clk),
        .rst         (rst),
        .fg_out      (fg_out),
        .alarm_level (alarm_level),
        .stats       (stats),
        .stats_valid (stats_valid)
    );

endmodule

`default_nettype wire

// ==== design/motion_pkg.sv ====
// shared types for the motion detector
// pixel and address types, stream and result structs, control states
`default_nettype none

package motion_pkg;

`include "motion_settings.svh"

    typedef logic [`MD_PIX_W-1:0]  pixel_t;
    typedef logic [`MD_ADDR_W-1:0] addr_t;
    typedef logic [`MD_PIX_W:0]    thresh_t;    // one bit above a pixel, 9 bits
    typedef logic [`MD_ADDR_W:0]   count_t;     // holds a full frame

    // camera side, sof strobes one cycle ahead of the first pixel
    typedef struct packed {
        logic   sof;
        logic   valid;
        pixel_t pixel;
    } cam_beat_t;

    typedef struct packed {
        addr_t  addr;
        pixel_t pixel;      // live pixel, aligned with the model read
        logic   active;
    } fetch_beat_t;

    typedef struct packed {
        logic   valid;
        addr_t  addr;
        logic   flag;       // foreground decision
        pixel_t pixel;      // live value on foreground, else zero
    } fg_out_t;

    typedef struct packed {
        logic   en;
        addr_t  addr;
        pixel_t data;
    } bg_wr_t;

    typedef struct packed {
        count_t count;
        logic   alarm;
    } frame_stats_t;

    typedef enum logic [2:0] {IDLE, ARM, CAPTURE, TRACK, DRAIN} det_state_e;

endpackage

`default_nettype wire

// ==== design/motion_stats.sv ====
// per-frame foreground count and motion alarm
`timescale 1ns/1ps
`default_nettype none

`include "motion_settings.svh"

module motion_stats
    import motion_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  fg_out_t      fg_out,
    input  count_t       alarm_level,
    output frame_stats_t stats,
    output logic         stats_valid
);

    localparam addr_t LAST_RES = addr_t'(`MD_FRAME_PIXELS - 1);

    addr_t  res_cnt;        // results seen in this frame
    count_t fg_cnt;         // foreground results before the current one
    count_t frame_cnt;      // including the current result
    logic   frame_end;

    assign frame_cnt = fg_cnt + count_t'(fg_out.flag);
    assign frame_end = fg_out.valid && (res_cnt == LAST_RES);

    always_ff @(posedge clk) begin
        if (rst) begin
            res_cnt     <= '0;
            fg_cnt      <= '0;
            stats_valid <= 1'b0;
        end else begin
            stats_valid <= frame_end;           // one-cycle pulse
            if (frame_end) begin
                res_cnt <= '0;
                fg_cnt  <= '0;
            end else if (fg_out.valid) begin
                res_cnt <= res_cnt + 1'b1;
                fg_cnt  <= frame_cnt;
            end
        end
    end

    // report held until the next frame closes
    always_ff @(posedge clk) begin
        if (frame_end) begin
            stats.count <= frame_cnt;
            stats.alarm <= frame_cnt > alarm_level;
        end
    end

endmodule

`default_nettype wire

// ==== design/pixel_fetch.sv ====
// pixel address counter and background read issue
// aligns the live pixel with the model read data
`timescale 1ns/1ps
`default_nettype none

`include "motion_settings.svh"

module pixel_fetch
    import motion_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cam_beat_t   cam,
    input  logic        accept,
    output addr_t       rd_addr,
    output fetch_beat_t beat,
    output logic        frame_done
);

    localparam addr_t LAST_ADDR = addr_t'(`MD_FRAME_PIXELS - 1);

    addr_t  next_addr;      // address the next accepted pixel gets
    addr_t  addr_q;         // address of the sampled pixel, drives the read
    pixel_t pix_q;
    logic   act_q;
    addr_t  beat_addr;      // second register, lines up with rd_data
    pixel_t beat_pix;
    logic   beat_act;
    logic   take;

    assign take = cam.valid & accept;   // dropped pixels never count

    // control side
    always_ff @(posedge clk) begin
        if (rst) begin
            next_addr  <= '0;
            act_q      <= 1'b0;
            beat_act   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            act_q      <= take;
            beat_act   <= act_q;
            frame_done <= take && (next_addr == LAST_ADDR);
            if (cam.sof) begin
                next_addr <= '0;                                    // new frame
            end else if (take) begin
                next_addr <= (next_addr == LAST_ADDR) ? '0 : next_addr + 1'b1;
            end
        end
    end

    // payload only moves on accepted pixels
    always_ff @(posedge clk) begin
        if (take) begin
            addr_q <= next_addr;
            pix_q  <= cam.pixel;
        end
        beat_addr <= addr_q;
        beat_pix  <= pix_q;
    end

    assign rd_addr = addr_q;
    assign beat    = '{addr: beat_addr, pixel: beat_pix, active: beat_act};

endmodule

`default_nettype wire

// ==== include/motion_settings.svh ====
// build-time constants for the motion detector
// frame geometry, data widths, learning rates, pipeline depth
`ifndef MOTION_SETTINGS_SVH
`define MOTION_SETTINGS_SVH

// ======================================================================
// frame geometry
// ======================================================================
`define MD_FRAME_PIXELS 256     // pixels per frame, kept small for simulation
`define MD_ADDR_W       8       // enough bits to address one frame

// ======================================================================
// pixel path
// ======================================================================
`define MD_PIX_W        8       // grayscale pixel width

// learning rates as right shifts of the signed difference
`define MD_BG_SHIFT     3       // background pixels follow at 1/8
`define MD_FG_SHIFT     8       // foreground pixels creep in at 1/256

// stages in adaptive_background, the control drains this many plus one
`define MD_PIPE_DEPTH   3

`endif

// ==== tests/tb_motion_detect.sv ====
// testbench for the motion detector top level
// random frames from a fixed seed, reference background model, result and stats checks
`timescale 1ns/1ps
`default_nettype none

`include "motion_settings.svh"

module tb_motion_detect
    import motion_pkg::*;
();

    // expected per-pixel result with due as the rising edge that sampled the pixel
    typedef struct packed {
        addr_t       addr;
        logic        flag;
        pixel_t      pixel;
        pixel_t      new_bg;
        logic [31:0] due;
    } exp_res_t;

    logic         clk;
    logic         rst;
    cam_beat_t    cam;
    logic         start;
    logic         stop;
    thresh_t      threshold;
    count_t       alarm_level;
    fg_out_t      fg_out;
    frame_stats_t stats;
    logic         stats_valid;
    logic         busy;

    pixel_t       bg_model [`MD_FRAME_PIXELS];  // reference copy of the background
    exp_res_t     res_q [$];                    // results still in flight
    frame_stats_t stats_q [$];                  // frame reports still due
    logic [31:0]  cycle;                        // rising edges since time zero
    logic [31:0]  last_res_cycle;
    int           scene_base;                   // drifting scene brightness

    motion_detect_top dut (
        .clk         (clk),
        .rst         (rst),
        .cam         (cam),
        .start       (start),
        .stop        (stop),
        .threshold   (threshold),
        .alarm_level (alarm_level),
        .fg_out      (fg_out),
        .stats       (stats),
        .stats_valid (stats_valid),
        .busy        (busy)
    );

    always #20 clk = ~clk;      // 40 ns period

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ======================================================================
    // failure reporting and helpers
    // ======================================================================
    task automatic abort_run;
        $display("sim failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic fail_because(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic int clamp_range(input int v, input int lo, input int hi);
        if (v < lo) return lo;
        if (v > hi) return hi;
        return v;
    endfunction

    // known power-up contents where the odd multiplier makes every address bit count
    function automatic pixel_t power_up_value(input int a);
        return pixel_t'(a * 37 + 91);
    endfunction

    // ======================================================================
    // stimulus tasks
    // ======================================================================
    task automatic run_frame(input logic capture, input logic stop_mid);
        int           a;
        int           p;
        int           d;
        int           mag;
        int           nb;
        int           patch_lo;
        int           patch_hi;
        int           fg_count;
        logic         flag;
        exp_res_t     e;
        frame_stats_t s;

        scene_base = clamp_range(scene_base + int'($urandom_range(16, 0)) - 8, 40, 180);
        patch_lo   = int'($urandom_range(`MD_FRAME_PIXELS - 1, 0));
        patch_hi   = patch_lo + int'($urandom_range(48, 0));   // bright object span
        fg_count   = 0;

        @(negedge clk);
        threshold   = thresh_t'($urandom_range(40, 8));
        alarm_level = count_t'($urandom_range(80, 0));
        cam.sof     = 1'b1;         // first pixel follows on the next cycle
        cam.valid   = 1'b0;
        for (a = 0; a < `MD_FRAME_PIXELS; a++) begin
            if (a > 0) begin
                repeat ($urandom_range(3, 0)) begin
                    @(negedge clk);
                    cam.valid = 1'b0;   // gap in the stream
                    stop      = 1'b0;
                end
            end
            @(negedge clk);
            if (a >= patch_lo && a <= patch_hi) begin
                p = int'($urandom_range(255, 200));
            end else begin
                p = clamp_range(scene_base + int'($urandom_range(12, 0)) - 6, 0, 255);
            end
            cam.sof   = 1'b0;
            cam.valid = 1'b1;
            cam.pixel = pixel_t'(p);
            stop      = stop_mid && (a == `MD_FRAME_PIXELS / 2);

            // reference decision against the model before this frame's update
            d    = p - int'(bg_model[a]);
            mag  = (d < 0) ? -d : d;
            flag = mag > int'(threshold);
            if (capture) begin
                nb = p;                                         // model takes the live value
            end else if (flag) begin
                nb = clamp_range(int'(bg_model[a]) + (d >>> `MD_FG_SHIFT), 0, 255);
            end else begin
                nb = clamp_range(int'(bg_model[a]) + (d >>> `MD_BG_SHIFT), 0, 255);
            end
            bg_model[a] = pixel_t'(nb);
            if (flag) fg_count++;

            e.addr   = addr_t'(a);
            e.flag   = flag;
            e.pixel  = flag ? pixel_t'(p) : '0;
            e.new_bg = pixel_t'(nb);
            e.due    = cycle + 1;       // edge that samples this pixel
            res_q.push_back(e);
        end

        s.count = count_t'(fg_count);
        s.alarm = fg_count > int'(alarm_level);
        stats_q.push_back(s);

        // quiet gap so threshold and alarm_level hold until the frame is out
        repeat (8) begin
            @(negedge clk);
            cam.valid = 1'b0;
            stop      = 1'b0;
        end
    endtask

    // pixels sent while idle must never reach the outputs
    task automatic send_idle_pixels(input int n);
        int i;

        @(negedge clk);
        cam.sof   = 1'b1;
        cam.valid = 1'b0;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            cam.sof   = 1'b0;
            cam.valid = 1'($urandom_range(1, 0));
            cam.pixel = pixel_t'($urandom);
            check_equal("busy", busy, 0);
            check_equal("fg_out.valid", fg_out.valid, 0);
            check_equal("stats_valid", stats_valid, 0);
        end
        @(negedge clk);
        cam.valid = 1'b0;
    endtask

    task automatic start_run;
        int waited;

        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        waited = 0;
        while (busy !== 1'b1) begin
            if (waited == 10) fail_because("busy did not rise after start");
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic wait_until_idle;
        int waited;

        waited = 0;
        while (busy !== 1'b0) begin
            if (waited == 50) fail_because("busy stayed high after stop");
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic wait_results_drained;
        int waited;

        waited = 0;
        while (res_q.size() != 0 || stats_q.size() != 0) begin
            if (waited == 50) fail_because("expected results or frame stats never arrived");
            @(negedge clk);
            waited++;
        end
    endtask

    // ======================================================================
    // output monitor sampling on the falling edge
    // ======================================================================
    always @(negedge clk) begin : monitor
        exp_res_t     e;
        frame_stats_t s;

        if (rst === 1'b0 && fg_out.valid !== 1'b0) begin
            if (res_q.size() == 0) begin
                fail_because("result on fg_out with no pixel pending");
            end else begin
                e = res_q.pop_front();
                check_equal("fg_out.valid", fg_out.valid, 1);
                check_equal("fg_out.addr", fg_out.addr, e.addr);
                check_equal("fg_out.flag", fg_out.flag, e.flag);
                check_equal("fg_out.pixel", fg_out.pixel, e.pixel);
                check_equal("fg_out latency", cycle - e.due, 4);
                check_equal("bg_wr.en", dut.bg_wr.en, 1);             // write rides with the result
                check_equal("bg_wr.addr", dut.bg_wr.addr, e.addr);
                check_equal("bg_wr.data", dut.bg_wr.data, e.new_bg);
                last_res_cycle = cycle;
            end
        end
        if (rst === 1'b0 && stats_valid !== 1'b0) begin
            if (stats_q.size() == 0) begin
                fail_because("stats_valid pulsed with no frame pending");
            end else begin
                s = stats_q.pop_front();
                check_equal("stats_valid", stats_valid, 1);
                check_equal("stats.count", stats.count, s.count);
                check_equal("stats.alarm", stats.alarm, s.alarm);
                check_equal("stats_valid timing", cycle - last_res_cycle, 1);
            end
        end
    end

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin : stimulus
        int unsigned seed;
        int          i;

        seed = 32'hf07836eb;
        void'($urandom(seed));          // single seeding of the generator

        clk            = 1'b0;
        rst            = 1'b1;
        cam            = '0;
        start          = 1'b0;
        stop           = 1'b0;
        threshold      = '0;
        alarm_level    = '0;
        cycle          = '0;
        last_res_cycle = '0;
        scene_base     = 100;

        for (i = 0; i < `MD_FRAME_PIXELS; i++) begin
            dut.u_ram.mem[i] = power_up_value(i);
            bg_model[i]      = power_up_value(i);
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        send_idle_pixels(40);           // nothing before start

        start_run();
        run_frame(1'b1, 1'b0);          // capture frame
        run_frame(1'b0, 1'b0);
        run_frame(1'b0, 1'b0);
        run_frame(1'b0, 1'b1);          // stop lands mid frame
        wait_until_idle();
        wait_results_drained();

        send_idle_pixels(40);           // stopped so pixels are dropped

        start_run();
        run_frame(1'b1, 1'b0);          // fresh capture after restart
        wait_results_drained();

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
design/motion_pkg.sv
design/bg_model_ram.sv
design/pixel_fetch.sv
design/adaptive_background.sv
design/motion_stats.sv
design/detect_ctrl.sv
design/motion_detect_top.sv
tests/tb_motion_detect.sv
